//--- cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_W = 32;
    localparam int REG_SEL_W = 4;
    localparam int ALU_SEL_W = 3;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    typedef logic [ALU_SEL_W-1:0] alu_sel_t;

    // ALU operation codes
    localparam alu_sel_t OP_ADD = 3'd0;
    localparam alu_sel_t OP_SUB = 3'd1;
    localparam alu_sel_t OP_OR = 3'd2;
    localparam alu_sel_t OP_AND = 3'd3;
    localparam alu_sel_t OP_XOR = 3'd4;
    localparam alu_sel_t OP_RESV = 3'd5;
    localparam alu_sel_t OP_CLAMP = 3'd6;
    localparam alu_sel_t OP_MUL = 3'd7;

    // Special register numbers
    localparam reg_sel_t REG_ZERO = 4'd0;
    localparam reg_sel_t REG_RA = 4'd11;
    localparam reg_sel_t REG_N = 4'd14;
    localparam reg_sel_t REG_PC = 4'd15;

    // Storage is r1..r14 minus ra
    localparam int REG_COUNT = REG_N - 1;

    // Instruction word layout
    localparam int JMP_BIT = 31;
    localparam int RRD_BIT = 28;
    localparam int RD_HI = 27;
    localparam int RD_LO = 24;
    localparam int ALU_HI = 23;
    localparam int ALU_LO = 21;
    localparam int RS_HI = 20;
    localparam int RS_LO = 17;
    localparam int IMM_EN_BIT = 16;
    localparam int SIGN_BIT = 15;
    localparam int IMM_HI = 14;
    localparam int IMM_LO = 0;
    localparam int RT_HI = 11;
    localparam int RT_LO = 8;
    localparam int JREL_HI = 7;
    localparam int JREL_LO = 0;
    localparam int CRD_BIT = 0;

    // add r0 = r0 + r0
    localparam word_t NOP_WORD = '0;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        alu_sel_t alu;
        word_t    imm;
        word_t    jmprel;
        logic     imm_en;
        logic     jmp_en;
        logic     r_rd_en;
        logic     c_rd_en;
    } dec_t;

    typedef struct packed {
        word_t    sval;
        word_t    tval;
        word_t    rdval;
        alu_sel_t alu;
        reg_sel_t rd;
        word_t    jmprel;
        logic     jmp_en;
    } opnd_t;

    typedef struct packed {
        reg_sel_t rd;
        word_t    val;
    } result_t;

endpackage

//--- cpu_fetch.sv
module cpu_fetch (
    input  logic           clk,
    input  logic           rst,
    input  logic           jmp_en_i,
    input  cpu_pkg::word_t jmp_pc_i,
    input  cpu_pkg::word_t p_data_i,
    output cpu_pkg::word_t p_addr_o,
    output cpu_pkg::word_t inst_o
);

    import cpu_pkg::*;

    word_t pc_q;

    // Jump target wins over the sequential step
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (jmp_en_i) begin
            pc_q <= jmp_pc_i;
        end else begin
            pc_q <= pc_q + word_t'(1);
        end
    end

    assign p_addr_o = pc_q;

    // Program memory answers in the same cycle
    assign inst_o = p_data_i;

endmodule

//--- cpu_decode.sv
module cpu_decode (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::word_t inst_i,
    output cpu_pkg::dec_t  dec_o
);

    import cpu_pkg::*;

    dec_t dec_q;

    function automatic dec_t decode_inst(word_t inst);
        dec_t d;
        logic jmp;
        logic imm_en;
        jmp = inst[JMP_BIT];
        imm_en = inst[IMM_EN_BIT];

        d.rs = inst[RS_HI:RS_LO];
        d.rt = inst[RT_HI:RT_LO];
        d.rd = inst[RD_HI:RD_LO];
        d.alu = inst[ALU_HI:ALU_LO];

        // Both constants extend from the same sign bit
        d.imm = {{(WORD_W - IMM_HI - 1){inst[SIGN_BIT]}}, inst[IMM_HI:IMM_LO]};
        d.jmprel = {{(WORD_W - JREL_HI - 1){inst[SIGN_BIT]}}, inst[JREL_HI:JREL_LO]};

        d.imm_en = imm_en;
        d.jmp_en = jmp;

        // Jumps never touch the data buses
        d.r_rd_en = inst[RRD_BIT] & ~jmp;
        // C read flag shares bit 0 with the immediate
        d.c_rd_en = inst[CRD_BIT] & ~jmp & ~imm_en;
        return d;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_q <= decode_inst(NOP_WORD);
        end else begin
            dec_q <= decode_inst(inst_i);
        end
    end

    assign dec_o = dec_q;

endmodule

//--- cpu_regfile.sv
module cpu_regfile (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_sel_t rs_sel_i,
    input  cpu_pkg::reg_sel_t rt_sel_i,
    input  cpu_pkg::reg_sel_t rd_sel_i,
    output cpu_pkg::word_t    rs_val_o,
    output cpu_pkg::word_t    rt_val_o,
    output cpu_pkg::word_t    rd_val_o,
    input  cpu_pkg::result_t  wr_i
);

    import cpu_pkg::*;

    word_t regs_q [REG_COUNT];

    // r0, ra and pc have no storage behind them
    function automatic logic is_storage(reg_sel_t sel);
        return (sel != REG_ZERO) && (sel != REG_RA) && (sel != REG_PC);
    endfunction

    // Packs r1..r10 and r12..n into a dense array
    function automatic logic [3:0] store_idx(reg_sel_t sel);
        if (sel < REG_RA) begin
            return sel - reg_sel_t'(1);
        end else begin
            return sel - reg_sel_t'(2);
        end
    endfunction

    always_comb begin
        rs_val_o = '0;
        rt_val_o = '0;
        rd_val_o = '0;
        if (is_storage(rs_sel_i)) begin
            rs_val_o = regs_q[store_idx(rs_sel_i)];
        end
        if (is_storage(rt_sel_i)) begin
            rt_val_o = regs_q[store_idx(rt_sel_i)];
        end
        if (is_storage(rd_sel_i)) begin
            rd_val_o = regs_q[store_idx(rd_sel_i)];
        end
    end

    // Writes to r0, ra and pc are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (is_storage(wr_i.rd)) begin
            regs_q[store_idx(wr_i.rd)] <= wr_i.val;
        end
    end

endmodule

//--- cpu_operand.sv
module cpu_operand (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::dec_t  dec_i,
    input  cpu_pkg::word_t rs_val_i,
    input  cpu_pkg::word_t rt_val_i,
    input  cpu_pkg::word_t rd_val_i,
    input  cpu_pkg::word_t r_data_i,
    input  cpu_pkg::word_t c_data_i,
    output cpu_pkg::word_t r_addr_o,
    output cpu_pkg::word_t c_addr_o,
    output logic           r_re_o,
    output logic           c_re_o,
    output cpu_pkg::opnd_t opnd_o
);

    import cpu_pkg::*;

    word_t    r_addr_q;
    word_t    c_addr_q;
    logic     r_re_q;
    logic     c_re_q;
    word_t    rdval_q;
    alu_sel_t alu_q;
    reg_sel_t rd_q;
    word_t    jmprel_q;
    logic     jmp_en_q;

    // R is addressed by immediate or rt, C always by rs
    assign r_addr_o = dec_i.imm_en ? dec_i.imm : rt_val_i;
    assign c_addr_o = rs_val_i;
    assign r_re_o = dec_i.r_rd_en;
    assign c_re_o = dec_i.c_rd_en;

    always_ff @(posedge clk) begin
        r_addr_q <= r_addr_o;
        c_addr_q <= c_addr_o;
        rdval_q <= rd_val_i;
        alu_q <= dec_i.alu;
        jmprel_q <= dec_i.jmprel;
        if (rst) begin
            r_re_q <= 1'b0;
            c_re_q <= 1'b0;
            rd_q <= REG_ZERO;
            jmp_en_q <= 1'b0;
        end else begin
            r_re_q <= r_re_o;
            c_re_q <= c_re_o;
            rd_q <= dec_i.rd;
            jmp_en_q <= dec_i.jmp_en;
        end
    end

    // Without a read the address itself is the operand
    always_comb begin
        opnd_o.sval = c_re_q ? c_data_i : c_addr_q;
        opnd_o.tval = r_re_q ? r_data_i : r_addr_q;
        opnd_o.rdval = rdval_q;
        opnd_o.alu = alu_q;
        opnd_o.rd = rd_q;
        opnd_o.jmprel = jmprel_q;
        opnd_o.jmp_en = jmp_en_q;
    end

endmodule

//--- cpu_execute.sv
module cpu_execute (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::opnd_t   opnd_i,
    output cpu_pkg::result_t res_o,
    output logic             jmp_en_o,
    output cpu_pkg::word_t   jmp_pc_o
);

    import cpu_pkg::*;

    word_t   alu_val;
    result_t res_q;
    logic    jmp_en_q;
    word_t   jmp_pc_q;

    always_comb begin
        case (opnd_i.alu)
            OP_ADD: alu_val = opnd_i.sval + opnd_i.tval;
            OP_SUB: alu_val = opnd_i.sval - opnd_i.tval;
            OP_OR: alu_val = opnd_i.sval | opnd_i.tval;
            OP_AND: alu_val = opnd_i.sval & opnd_i.tval;
            OP_XOR: alu_val = opnd_i.sval ^ opnd_i.tval;
            // Not implemented in this core
            OP_RESV, OP_CLAMP, OP_MUL: alu_val = '0;
            default: alu_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        res_q.val <= alu_val;
        // Target is relative to the rd register value
        jmp_pc_q <= opnd_i.rdval + opnd_i.jmprel;
        if (rst) begin
            res_q.rd <= REG_ZERO;
            jmp_en_q <= 1'b0;
        end else begin
            res_q.rd <= opnd_i.rd;
            jmp_en_q <= opnd_i.jmp_en;
        end
    end

    assign res_o = res_q;
    assign jmp_en_o = jmp_en_q;
    assign jmp_pc_o = jmp_pc_q;

endmodule

//--- nkmd_cpu.sv
module nkmd_cpu (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::word_t p_data_i,
    output cpu_pkg::word_t p_addr_o,
    input  cpu_pkg::word_t r_data_i,
    output cpu_pkg::word_t r_addr_o,
    output logic           r_re_o,
    input  cpu_pkg::word_t c_data_i,
    output cpu_pkg::word_t c_addr_o,
    output logic           c_re_o
);

    import cpu_pkg::*;

    word_t   inst;
    dec_t    dec;
    word_t   rs_val;
    word_t   rt_val;
    word_t   rd_val;
    opnd_t   opnd;
    result_t res;
    logic    jmp_en;
    word_t   jmp_pc;

    cpu_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .jmp_en_i (jmp_en),
        .jmp_pc_i (jmp_pc),
        .p_data_i (p_data_i),
        .p_addr_o (p_addr_o),
        .inst_o   (inst)
    );

    cpu_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .inst_i (inst),
        .dec_o  (dec)
    );

    // Result is written back straight from the execute registers
    cpu_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs_sel_i (dec.rs),
        .rt_sel_i (dec.rt),
        .rd_sel_i (dec.rd),
        .rs_val_o (rs_val),
        .rt_val_o (rt_val),
        .rd_val_o (rd_val),
        .wr_i     (res)
    );

    cpu_operand u_operand (
        .clk      (clk),
        .rst      (rst),
        .dec_i    (dec),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .rd_val_i (rd_val),
        .r_data_i (r_data_i),
        .c_data_i (c_data_i),
        .r_addr_o (r_addr_o),
        .c_addr_o (c_addr_o),
        .r_re_o   (r_re_o),
        .c_re_o   (c_re_o),
        .opnd_o   (opnd)
    );

    cpu_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .opnd_i   (opnd),
        .res_o    (res),
        .jmp_en_o (jmp_en),
        .jmp_pc_o (jmp_pc)
    );

endmodule

//--- cpu_asserts.sv
module cpu_asserts (
    input logic           clk,
    input logic           rst,
    input cpu_pkg::word_t p_addr_i,
    input cpu_pkg::word_t p_data_i,
    input cpu_pkg::word_t r_addr_i,
    input logic           r_re_i,
    input cpu_pkg::word_t c_addr_i,
    input logic           c_re_i,
    input logic           jmp_en_i,
    input cpu_pkg::word_t jmp_pc_i
);

    import cpu_pkg::*;

    // Decode register holds a NOP right after reset
    strobes_idle_after_reset: assert property (
        @(posedge clk) rst |=> (!r_re_i && !c_re_i)
    ) else $error("read strobe high in the cycle after reset");

    // PC steps by one unless a jump was pending
    pc_sequence: assert property (
        @(posedge clk) !rst |=> (p_addr_i == ($past(jmp_en_i) ? $past(jmp_pc_i)
                                              : $past(p_addr_i) + word_t'(1)))
    ) else $error("program address neither incremented nor followed a jump");

    r_addr_known: assert property (
        @(posedge clk) r_re_i |-> !$isunknown(r_addr_i)
    ) else $error("R bus address unknown while strobed");

    c_addr_known: assert property (
        @(posedge clk) c_re_i |-> !$isunknown(c_addr_i)
    ) else $error("C bus address unknown while strobed");

    // Bit 0 belongs to the immediate once that word sits in decode
    no_c_read_with_imm: assert property (
        @(posedge clk) p_data_i[IMM_EN_BIT] |=> !c_re_i
    ) else $error("C read strobe high with immediate enabled");

endmodule

bind nkmd_cpu cpu_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .p_addr_i (p_addr_o),
    .p_data_i (p_data_i),
    .r_addr_i (r_addr_o),
    .r_re_i   (r_re_o),
    .c_addr_i (c_addr_o),
    .c_re_i   (c_re_o),
    .jmp_en_i (jmp_en),
    .jmp_pc_i (jmp_pc)
);

//--- tb_cpu.sv
module tb_cpu;

    import cpu_pkg::*;

    localparam int SEED = 74914;
    localparam int PROG_LEN = 256;
    localparam int STEP_LIMIT = 300;
    localparam int RUN_CYCLES = STEP_LIMIT * 4;
    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT = (RUN_CYCLES + 2) * CLK_PERIOD + 100 * CLK_PERIOD;
    localparam word_t R_KEY = 32'h5a3c_96e1;
    localparam word_t C_KEY = 32'hc3a5_0f72;

    typedef struct packed {
        logic  re;
        word_t addr;
    } bus_req_t;

    logic     clk;
    logic     rst;
    word_t    p_data;
    word_t    p_addr;
    word_t    r_data;
    word_t    r_addr;
    logic     r_re;
    word_t    c_data;
    word_t    c_addr;
    logic     c_re;
    bus_req_t r_prev;
    bus_req_t c_prev;

    word_t prog [PROG_LEN];
    word_t model_regs [16];
    int    errors;
    int    checks;
    int    jumps;

    nkmd_cpu uut (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data),
        .p_addr_o (p_addr),
        .r_data_i (r_data),
        .r_addr_o (r_addr),
        .r_re_o   (r_re),
        .c_data_i (c_data),
        .c_addr_o (c_addr),
        .c_re_o   (c_re)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // r0, ra and pc always read back as zero
    function automatic word_t model_reg(reg_sel_t sel);
        if (sel == REG_ZERO || sel == REG_RA || sel == REG_PC) begin
            return '0;
        end
        return model_regs[sel];
    endfunction

    function automatic word_t model_alu(alu_sel_t op, word_t s, word_t t);
        case (op)
            OP_ADD: return s + t;
            OP_SUB: return s - t;
            OP_OR: return s | t;
            OP_AND: return s & t;
            OP_XOR: return s ^ t;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual,
                               input int cyc);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h got %h at cycle %0d", name, expected, actual, cyc);
        end
    endtask

    // One real instruction per group of four, the rest NOPs
    task automatic gen_program();
        word_t ins;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = NOP_WORD;
        end
        for (int g = 0; g < PROG_LEN / 4; g++) begin
            ins = $urandom();
            ins[31] = 1'b0;
            // Forward jump to a later group start, based on r0
            if (($urandom() % 6 == 0) && (g < PROG_LEN / 4 - 1)) begin
                ins[31] = 1'b1;
                ins[27:24] = REG_ZERO;
                ins[15] = 1'b0;
                ins[7:0] = 8'((g + 1 + $urandom() % (PROG_LEN / 4 - 1 - g)) * 4);
            end
            prog[g * 4] = ins;
        end
    endtask

    // Memories answer one cycle after the strobe
    task automatic serve_buses();
        r_data = r_prev.re ? (r_prev.addr ^ R_KEY) : $urandom();
        c_data = c_prev.re ? (c_prev.addr ^ C_KEY) : $urandom();
        r_prev.re = r_re;
        r_prev.addr = r_addr;
        c_prev.re = c_re;
        c_prev.addr = c_addr;
        p_data = prog[p_addr[7:0]];
    endtask

    task automatic step_model(input word_t pc, output word_t nxt, input int cyc);
        word_t    ins;
        logic     jmp;
        logic     imm_en;
        logic     r_en;
        logic     c_en;
        reg_sel_t rd;
        word_t    imm;
        word_t    jrel;
        word_t    r_exp;
        word_t    c_exp;
        word_t    sval;
        word_t    tval;
        word_t    res;
        ins = prog[pc[7:0]];
        jmp = ins[31];
        imm_en = ins[16];
        rd = ins[27:24];
        imm = {{17{ins[15]}}, ins[14:0]};
        jrel = {{24{ins[15]}}, ins[7:0]};
        r_en = ins[28] & ~jmp;
        c_en = ins[0] & ~jmp & ~imm_en;
        r_exp = imm_en ? imm : model_reg(ins[11:8]);
        c_exp = model_reg(ins[20:17]);
        check_value("r_re_o", word_t'(r_en), word_t'(r_re), cyc);
        check_value("c_re_o", word_t'(c_en), word_t'(c_re), cyc);
        check_value("r_addr_o", r_exp, r_addr, cyc);
        check_value("c_addr_o", c_exp, c_addr, cyc);
        tval = r_en ? (r_exp ^ R_KEY) : r_exp;
        sval = c_en ? (c_exp ^ C_KEY) : c_exp;
        res = model_alu(alu_sel_t'(ins[23:21]), sval, tval);
        if (jmp) begin
            nxt = model_reg(rd) + jrel;
            jumps++;
        end else begin
            nxt = pc + 32'd4;
        end
        if (rd != REG_ZERO && rd != REG_RA && rd != REG_PC) begin
            model_regs[rd] = res;
        end
    endtask

    initial begin
        word_t grp_pc;
        word_t next_pc;
        word_t exp_fetch;
        clk = 1'b0;
        rst = 1'b1;
        p_data = '0;
        r_data = '0;
        c_data = '0;
        r_prev = '0;
        c_prev = '0;
        errors = 0;
        checks = 0;
        jumps = 0;
        void'($urandom(SEED));
        gen_program();
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        grp_pc = '0;
        next_pc = '0;
        repeat (2) @(posedge clk);
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(negedge clk);
            rst = 1'b0;
            serve_buses();
            if (cyc % 4 == 0 && cyc > 0) begin
                grp_pc = next_pc;
            end
            exp_fetch = grp_pc + word_t'(cyc % 4);
            check_value("p_addr_o", exp_fetch, p_addr, cyc);
            if (cyc % 4 == 1) begin
                step_model(grp_pc, next_pc, cyc);
            end else begin
                // NOP in decode, so no reads and addresses from r0
                check_value("r_re_o", '0, word_t'(r_re), cyc);
                check_value("c_re_o", '0, word_t'(c_re), cyc);
                check_value("r_addr_o", '0, r_addr, cyc);
                check_value("c_addr_o", '0, c_addr, cyc);
            end
        end
        $display("Run finished: %0d checks, %0d errors, %0d jumps", checks, errors, jumps);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not complete within %0d time units", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verilog.f
cpu_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_regfile.sv
cpu_operand.sv
cpu_execute.sv
nkmd_cpu.sv
cpu_asserts.sv
tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cpu -f verilog.f \
    && ./obj_dir/Vtb_cpu | tee /dev/stderr | grep -q "^TEST PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
